// ==== compile.f ====
hw/calc_geom_pkg.sv
hw/calc_isa_pkg.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_issue.sv
hw/calc_completion.sv
hw/calculator_top.sv
verif/calculator_tb.sv

// ==== hw/calc_completion.sv ====
/*
  Completion pipe of the calculator.
  Carries tags and data through ex2, ex3 and wb, merges pipe results at
  their fixed latency, kills entries on flush and drives the bypass slices.
*/
`default_nettype none

module calc_completion
  (input  logic                                                  clk_i
  , input  logic                                                 rst_n_i
  , input  logic                                                 flush_i
  , input  logic                                                 ex1_v_i
  , input  calc_isa_pkg::calc_op_e                               ex1_op_i
  , input  calc_geom_pkg::reg_addr_t                             ex1_rd_addr_i
  , input  calc_geom_pkg::word_t                                 int_result_i
  , input  calc_geom_pkg::word_t                                 mul_result_i
  , output logic [calc_geom_pkg::fwd_stages-1:0]                 fwd_v_o
  , output calc_geom_pkg::reg_addr_t [calc_geom_pkg::fwd_stages-1:0] fwd_rd_addr_o
  , output calc_geom_pkg::word_t [calc_geom_pkg::fwd_stages-1:0] fwd_data_o
  , output logic                                                 wb_v_o
  , output calc_geom_pkg::reg_addr_t                             wb_rd_addr_o
  , output calc_geom_pkg::word_t                                 wb_data_o
  );

  localparam int depth = calc_geom_pkg::wb_latency;

  // Stage 1 is ex2, stage depth is wb
  logic [depth:1]                            v_q, v_n;
  logic [depth:1]                            mul_q, mul_n;
  calc_geom_pkg::reg_addr_t [depth:1]        rd_q, rd_n;
  calc_geom_pkg::word_t [depth:1]            data_q, data_n;

  always_comb
  begin
    // Writes to x0 never enter as valid
    v_n[1]    = ex1_v_i && (ex1_rd_addr_i != '0);
    mul_n[1]  = calc_isa_pkg::is_mul_op(ex1_op_i);
    rd_n[1]   = ex1_rd_addr_i;
    data_n[1] = '0;

    for (int k = 2; k <= depth; k++)
    begin
      v_n[k]    = v_q[k-1];
      mul_n[k]  = mul_q[k-1];
      rd_n[k]   = rd_q[k-1];
      data_n[k] = data_q[k-1];
    end

    for (int k = 1; k <= depth; k++)
    begin
      if ((k == calc_geom_pkg::int_latency) && !mul_n[k])
      begin
        data_n[k] = int_result_i;
      end
      if ((k == calc_geom_pkg::mul_latency) && mul_n[k])
      begin
        data_n[k] = mul_result_i;
      end
      // Poison everything short of the entry already in wb
      if (flush_i)
      begin
        v_n[k] = 1'b0;
      end
    end
  end

  // Next-state slices, a product counts only once it is merged
  always_comb
  begin
    for (int k = 1; k <= calc_geom_pkg::fwd_stages; k++)
    begin
      fwd_v_o[k-1]       = v_n[k] && (!mul_n[k] || (k >= calc_geom_pkg::mul_latency));
      fwd_rd_addr_o[k-1] = rd_n[k];
      fwd_data_o[k-1]    = data_n[k];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      v_q <= '0;
    end
    else
    begin
      v_q <= v_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    mul_q  <= mul_n;
    rd_q   <= rd_n;
    data_q <= data_n;
  end

  assign wb_v_o       = v_q[depth];
  assign wb_rd_addr_o = rd_q[depth];
  assign wb_data_o    = data_q[depth];

  wb_rd_nonzero_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_v_o |-> (wb_rd_addr_o != '0))
    else $error("Fail wb_rd_addr_o 0x%0h", wb_rd_addr_o);

  // The entry heading into wb is killed along with the younger ones
  flush_kills_wb_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !wb_v_o)
    else $error("Fail wb_v_o 0x%0h after flush", wb_v_o);

endmodule

`default_nettype wire

// ==== hw/calc_geom_pkg.sv ====
/*
  Data-path geometry shared by the calculator RTL and its testbench.
  Widths, the depth of the completion pipe and the fixed pipe latencies.
*/
`default_nettype none

package calc_geom_pkg;

  // Architectural widths
  localparam int word_width     = 32;
  localparam int reg_addr_width = 5;

  typedef logic [word_width-1:0]     word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  // Completion stage in which each pipe merges its result
  localparam int int_latency = 1;
  localparam int mul_latency = 2;

  // Dispatch edge to the edge that loads the wb entry
  localparam int wb_latency = 3;

  // Entries seen by the bypass network (ex2, ex3 and wb)
  localparam int fwd_stages = wb_latency;

endpackage

`default_nettype wire

// ==== hw/calc_isa_pkg.sv ====
/*
  Instruction encoding of the calculator core.
  Holds the operation enum and the split between the ALU and the multiplier.
*/
`default_nettype none

package calc_isa_pkg;

  // Operation code carried from dispatch to the execution pipes
  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_slt  = 3'd5,
    op_mul  = 3'd6,
    op_mulh = 3'd7
  } calc_op_e;

  // Ops served by the two-cycle multiplier
  function automatic logic is_mul_op(input calc_op_e op);
    return (op == op_mul) || (op == op_mulh);
  endfunction

endpackage

`default_nettype wire

// ==== hw/calc_issue.sv ====
/*
  Operand bypass and issue register of the calculator.
  Repairs stale register-file operands from the completion pipe and
  holds one instruction per cycle for the execution pipes.
*/
`default_nettype none

module calc_issue
  (input  logic                                                  clk_i
  , input  logic                                                 rst_n_i
  , input  logic                                                 dispatch_v_i
  , input  calc_isa_pkg::calc_op_e                               dispatch_op_i
  , input  calc_geom_pkg::reg_addr_t                             dispatch_rd_addr_i
  , input  calc_geom_pkg::reg_addr_t                             dispatch_rs1_addr_i
  , input  calc_geom_pkg::reg_addr_t                             dispatch_rs2_addr_i
  , input  calc_geom_pkg::word_t                                 dispatch_rs1_data_i
  , input  calc_geom_pkg::word_t                                 dispatch_rs2_data_i
  , input  logic                                                 flush_i
  , input  logic [calc_geom_pkg::fwd_stages-1:0]                 fwd_v_i
  , input  calc_geom_pkg::reg_addr_t [calc_geom_pkg::fwd_stages-1:0] fwd_rd_addr_i
  , input  calc_geom_pkg::word_t [calc_geom_pkg::fwd_stages-1:0] fwd_data_i
  , output logic                                                 ex1_v_o
  , output calc_isa_pkg::calc_op_e                               ex1_op_o
  , output calc_geom_pkg::reg_addr_t                             ex1_rd_addr_o
  , output calc_geom_pkg::word_t                                 ex1_rs1_o
  , output calc_geom_pkg::word_t                                 ex1_rs2_o
  );

  logic                     ex1_v_q;
  calc_isa_pkg::calc_op_e   ex1_op_q;
  calc_geom_pkg::reg_addr_t ex1_rd_addr_q;
  calc_geom_pkg::word_t     ex1_rs1_q;
  calc_geom_pkg::word_t     ex1_rs2_q;
  calc_geom_pkg::word_t     rs1_bypass;
  calc_geom_pkg::word_t     rs2_bypass;

  // Index 0 is the youngest source, so it is applied last
  function automatic calc_geom_pkg::word_t bypass_operand(
    input calc_geom_pkg::reg_addr_t addr,
    input calc_geom_pkg::word_t     rf_data
  );
    calc_geom_pkg::word_t value;
    value = rf_data;
    for (int i = calc_geom_pkg::fwd_stages - 1; i >= 0; i--)
    begin
      if (fwd_v_i[i] && (fwd_rd_addr_i[i] == addr))
      begin
        value = fwd_data_i[i];
      end
    end
    // x0 is hardwired
    if (addr == '0)
    begin
      value = '0;
    end
    return value;
  endfunction

  always_comb
  begin
    rs1_bypass = bypass_operand(dispatch_rs1_addr_i, dispatch_rs1_data_i);
    rs2_bypass = bypass_operand(dispatch_rs2_addr_i, dispatch_rs2_data_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ex1_v_q <= 1'b0;
    end
    else
    begin
      ex1_v_q <= dispatch_v_i && !flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ex1_op_q      <= dispatch_op_i;
    ex1_rd_addr_q <= dispatch_rd_addr_i;
    ex1_rs1_q     <= rs1_bypass;
    ex1_rs2_q     <= rs2_bypass;
  end

  assign ex1_v_o       = ex1_v_q;
  assign ex1_op_o      = ex1_op_q;
  assign ex1_rd_addr_o = ex1_rd_addr_q;
  assign ex1_rs1_o     = ex1_rs1_q;
  assign ex1_rs2_o     = ex1_rs2_q;

  // A product is not in the completion pipe until ex3, so back-to-back use is illegal
  mul_use_hazard_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dispatch_v_i && !flush_i && ex1_v_q && calc_isa_pkg::is_mul_op(ex1_op_q)
      && (ex1_rd_addr_q != '0)
      && ((dispatch_rs1_addr_i == ex1_rd_addr_q) || (dispatch_rs2_addr_i == ex1_rd_addr_q))))
    else $error("Fail mul_use_hazard rd 0x%0h", ex1_rd_addr_q);

endmodule

`default_nettype wire

// ==== hw/calc_pipe_int.sv ====
/*
  Integer ALU pipe with a single cycle of latency.
  Purely combinational, its result is merged into ex2 by the completion pipe.
*/
`default_nettype none

module calc_pipe_int
  (input  calc_isa_pkg::calc_op_e op_i
  , input  calc_geom_pkg::word_t  rs1_i
  , input  calc_geom_pkg::word_t  rs2_i
  , output calc_geom_pkg::word_t  result_o
  );

  logic rs1_lt_rs2;

  // Signed compare for slt
  assign rs1_lt_rs2 = $signed(rs1_i) < $signed(rs2_i);

  always_comb
  begin
    case (op_i)
      calc_isa_pkg::op_add:
        result_o = rs1_i + rs2_i;
      calc_isa_pkg::op_sub:
        result_o = rs1_i - rs2_i;
      calc_isa_pkg::op_and:
        result_o = rs1_i & rs2_i;
      calc_isa_pkg::op_or:
        result_o = rs1_i | rs2_i;
      calc_isa_pkg::op_xor:
        result_o = rs1_i ^ rs2_i;
      calc_isa_pkg::op_slt:
        result_o = calc_geom_pkg::word_t'(rs1_lt_rs2);
      // Multiplies are taken from the other pipe
      default:
        result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/calc_pipe_mul.sv ====
/*
  Two-cycle signed multiplier pipe.
  The full product is registered at the end of ex1 and the half
  selected by the captured op is returned during ex2.
*/
`default_nettype none

module calc_pipe_mul
  (input  logic                   clk_i
  , input  logic                  rst_n_i
  , input  calc_isa_pkg::calc_op_e op_i
  , input  calc_geom_pkg::word_t  rs1_i
  , input  calc_geom_pkg::word_t  rs2_i
  , output calc_geom_pkg::word_t  result_o
  );

  localparam int prod_width = 2 * calc_geom_pkg::word_width;

  logic [prod_width-1:0]  product_q;
  calc_isa_pkg::calc_op_e op_q;

  // Op travels next to the product to pick the half
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      op_q <= calc_isa_pkg::op_mul;
    end
    else
    begin
      op_q <= op_i;
    end
  end

  // Loaded every cycle, the completion pipe decides whether it is used
  always_ff @(posedge clk_i)
  begin
    product_q <= $signed(rs1_i) * $signed(rs2_i);
  end

  assign result_o = (op_q == calc_isa_pkg::op_mulh)
                  ? product_q[prod_width-1:calc_geom_pkg::word_width]
                  : product_q[calc_geom_pkg::word_width-1:0];

endmodule

`default_nettype wire

// ==== hw/calculator_top.sv ====
/*
  Calculator core top level.
  Takes one dispatched instruction per cycle with its register-file operands
  and returns a writeback strobe with destination and data three cycles later.
*/
`default_nettype none

module calculator_top
  (input  logic                     clk_i
  , input  logic                    rst_n_i
  , input  logic                    dispatch_v_i
  , input  calc_isa_pkg::calc_op_e  dispatch_op_i
  , input  calc_geom_pkg::reg_addr_t dispatch_rd_addr_i
  , input  calc_geom_pkg::reg_addr_t dispatch_rs1_addr_i
  , input  calc_geom_pkg::reg_addr_t dispatch_rs2_addr_i
  , input  calc_geom_pkg::word_t    dispatch_rs1_data_i
  , input  calc_geom_pkg::word_t    dispatch_rs2_data_i
  , input  logic                    flush_i
  , output logic                    wb_v_o
  , output calc_geom_pkg::reg_addr_t wb_rd_addr_o
  , output calc_geom_pkg::word_t    wb_data_o
  );

  logic                                                  ex1_v;
  calc_isa_pkg::calc_op_e                                ex1_op;
  calc_geom_pkg::reg_addr_t                              ex1_rd_addr;
  calc_geom_pkg::word_t                                  ex1_rs1;
  calc_geom_pkg::word_t                                  ex1_rs2;
  calc_geom_pkg::word_t                                  int_result;
  calc_geom_pkg::word_t                                  mul_result;
  logic [calc_geom_pkg::fwd_stages-1:0]                  fwd_v;
  calc_geom_pkg::reg_addr_t [calc_geom_pkg::fwd_stages-1:0] fwd_rd_addr;
  calc_geom_pkg::word_t [calc_geom_pkg::fwd_stages-1:0]  fwd_data;

  calc_issue calc_issue_inst
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .dispatch_v_i(dispatch_v_i)
    , .dispatch_op_i(dispatch_op_i)
    , .dispatch_rd_addr_i(dispatch_rd_addr_i)
    , .dispatch_rs1_addr_i(dispatch_rs1_addr_i)
    , .dispatch_rs2_addr_i(dispatch_rs2_addr_i)
    , .dispatch_rs1_data_i(dispatch_rs1_data_i)
    , .dispatch_rs2_data_i(dispatch_rs2_data_i)
    , .flush_i(flush_i)
    , .fwd_v_i(fwd_v)
    , .fwd_rd_addr_i(fwd_rd_addr)
    , .fwd_data_i(fwd_data)
    , .ex1_v_o(ex1_v)
    , .ex1_op_o(ex1_op)
    , .ex1_rd_addr_o(ex1_rd_addr)
    , .ex1_rs1_o(ex1_rs1)
    , .ex1_rs2_o(ex1_rs2)
    );

  // ALU result is ready within ex1
  calc_pipe_int calc_pipe_int_inst
    (.op_i(ex1_op)
    , .rs1_i(ex1_rs1)
    , .rs2_i(ex1_rs2)
    , .result_o(int_result)
    );

  // Product arrives one cycle after ex1
  calc_pipe_mul calc_pipe_mul_inst
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .op_i(ex1_op)
    , .rs1_i(ex1_rs1)
    , .rs2_i(ex1_rs2)
    , .result_o(mul_result)
    );

  calc_completion calc_completion_inst
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .flush_i(flush_i)
    , .ex1_v_i(ex1_v)
    , .ex1_op_i(ex1_op)
    , .ex1_rd_addr_i(ex1_rd_addr)
    , .int_result_i(int_result)
    , .mul_result_i(mul_result)
    , .fwd_v_o(fwd_v)
    , .fwd_rd_addr_o(fwd_rd_addr)
    , .fwd_data_o(fwd_data)
    , .wb_v_o(wb_v_o)
    , .wb_rd_addr_o(wb_rd_addr_o)
    , .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module calculator_tb

output=$(./obj_dir/Vcalculator_tb)
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

// ==== verif/calculator_tb.sv ====
/*
  Testbench for the calculator core.
  Feeds stale register-file operands, predicts writebacks with an in-order
  model and checks them with concurrent assertions sampled mid-cycle.
*/
`default_nettype none

module calculator_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    calc_geom_pkg::reg_addr_t rd;
    calc_geom_pkg::word_t     data;
    calc_geom_pkg::word_t     old;
    int                       step;
  } wb_entry_t;

  localparam int n_alu = 40;
  localparam int n_mul = 30;
  // Reset, the five tests with their drains, then a margin
  localparam int max_cycles = 16 + (n_alu + 8) + (n_mul + 8) + 40 + 20 + 32 + 100;

  logic clk;
  logic rst_n;
  logic dispatch_v;
  calc_isa_pkg::calc_op_e dispatch_op;
  calc_geom_pkg::reg_addr_t dispatch_rd_addr;
  calc_geom_pkg::reg_addr_t dispatch_rs1_addr;
  calc_geom_pkg::reg_addr_t dispatch_rs2_addr;
  calc_geom_pkg::word_t dispatch_rs1_data;
  calc_geom_pkg::word_t dispatch_rs2_data;
  logic flush;
  logic wb_v;
  calc_geom_pkg::reg_addr_t wb_rd_addr;
  calc_geom_pkg::word_t wb_data;
  logic disp_live;

  calc_geom_pkg::word_t model_rf [32];
  calc_geom_pkg::word_t stale_rf [32];
  wb_entry_t exp_q [$];
  logic head_v;
  calc_geom_pkg::reg_addr_t head_rd;
  calc_geom_pkg::word_t head_data;
  calc_geom_pkg::reg_addr_t prev_mul_rd;
  logic wb_pending;
  int step_count;
  int cycle_count;
  int errors;
  int errors_mark;
  int tests_done;
  int wb_count;

  calculator_top calculator_top_inst
    (.clk_i(clk)
    , .rst_n_i(rst_n)
    , .dispatch_v_i(dispatch_v)
    , .dispatch_op_i(dispatch_op)
    , .dispatch_rd_addr_i(dispatch_rd_addr)
    , .dispatch_rs1_addr_i(dispatch_rs1_addr)
    , .dispatch_rs2_addr_i(dispatch_rs2_addr)
    , .dispatch_rs1_data_i(dispatch_rs1_data)
    , .dispatch_rs2_data_i(dispatch_rs2_data)
    , .flush_i(flush)
    , .wb_v_o(wb_v)
    , .wb_rd_addr_o(wb_rd_addr)
    , .wb_data_o(wb_data)
    );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > max_cycles)
    begin
      $display("Timeout after %0d cycles with %0d writebacks pending", cycle_count, exp_q.size());
      $display("sim failed");
      $finish;
    end
  end

  assign disp_live = dispatch_v && (dispatch_rd_addr != '0) && !flush;

  wb_expected_a : assert property (@(negedge clk) disable iff (!rst_n)
    wb_v |-> head_v)
    else begin
      $display("Writeback to x%0d seen with no result expected", wb_rd_addr);
      errors = errors + 1;
    end

  wb_rd_a : assert property (@(negedge clk) disable iff (!rst_n)
    (wb_v && head_v) |-> (wb_rd_addr == head_rd))
    else begin
      $display("Fail wb_rd_addr_o got 0x%0h expected 0x%0h", wb_rd_addr, head_rd);
      errors = errors + 1;
    end

  wb_data_a : assert property (@(negedge clk) disable iff (!rst_n)
    (wb_v && head_v) |-> (wb_data == head_data))
    else begin
      $display("Fail wb_data_o got 0x%0h expected 0x%0h", wb_data, head_data);
      errors = errors + 1;
    end

  // A dispatch with no flush in the following three cycles must retire on time
  wb_latency_a : assert property (@(negedge clk) disable iff (!rst_n)
    ($past(disp_live, calc_geom_pkg::wb_latency + 1) && !$past(flush, 1)
      && !$past(flush, 2) && !$past(flush, 3)) |-> wb_v)
    else begin
      $display("Fail wb_v_o got 0x%0h expected 0x1", wb_v);
      errors = errors + 1;
    end

  function automatic calc_geom_pkg::word_t expected_result(input calc_isa_pkg::calc_op_e op,
    input calc_geom_pkg::word_t a, input calc_geom_pkg::word_t b);
    longint prod;
    prod = longint'(signed'(a)) * longint'(signed'(b));
    case (op)
      calc_isa_pkg::op_add: return a + b;
      calc_isa_pkg::op_sub: return a - b;
      calc_isa_pkg::op_and: return a & b;
      calc_isa_pkg::op_or:  return a | b;
      calc_isa_pkg::op_xor: return a ^ b;
      calc_isa_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_isa_pkg::op_mul: return prod[31:0];
      default:              return prod[63:32];
    endcase
  endfunction

  // Source register that never reads a product one dispatch after it issues
  function automatic calc_geom_pkg::reg_addr_t pick_src(input int lo, input int hi);
    calc_geom_pkg::reg_addr_t r;
    r = calc_geom_pkg::reg_addr_t'($urandom_range(hi, lo));
    while ((r != '0) && (r == prev_mul_rd))
    begin
      r = calc_geom_pkg::reg_addr_t'($urandom_range(hi, lo));
    end
    return r;
  endfunction

  task automatic refresh_head();
    head_v = exp_q.size() > 0;
    if (head_v)
    begin
      head_rd   = exp_q[0].rd;
      head_data = exp_q[0].data;
    end
  endtask

  // Retire the entry checked last cycle and write through the visible writeback
  task automatic cycle_step();
    @(posedge clk);
    #1;
    if (wb_pending && (exp_q.size() > 0))
    begin
      void'(exp_q.pop_front());
      wb_count = wb_count + 1;
    end
    wb_pending = wb_v;
    if (wb_v && (wb_rd_addr != '0))
    begin
      stale_rf[wb_rd_addr] = wb_data;
    end
    step_count = step_count + 1;
    refresh_head();
  endtask

  // Undo the model writes of everything younger than the wb entry
  task automatic discard_killed();
    while ((exp_q.size() > 0)
      && (exp_q[$].step >= step_count - calc_geom_pkg::wb_latency))
    begin
      model_rf[exp_q[$].rd] = exp_q[$].old;
      void'(exp_q.pop_back());
    end
  endtask

  task automatic send(input calc_isa_pkg::calc_op_e op, input calc_geom_pkg::reg_addr_t rd,
    input calc_geom_pkg::reg_addr_t rs1, input calc_geom_pkg::reg_addr_t rs2, input logic kill);
    wb_entry_t entry;
    cycle_step();
    if (kill)
    begin
      discard_killed();
    end
    dispatch_v        = 1'b1;
    dispatch_op       = op;
    dispatch_rd_addr  = rd;
    dispatch_rs1_addr = rs1;
    dispatch_rs2_addr = rs2;
    dispatch_rs1_data = stale_rf[rs1];
    dispatch_rs2_data = stale_rf[rs2];
    flush             = kill;
    if (!kill && (rd != '0))
    begin
      entry.rd   = rd;
      entry.data = expected_result(op, model_rf[rs1], model_rf[rs2]);
      entry.old  = model_rf[rd];
      entry.step = step_count;
      exp_q.push_back(entry);
      model_rf[rd] = entry.data;
    end
    if (!kill && ((op == calc_isa_pkg::op_mul) || (op == calc_isa_pkg::op_mulh)))
      prev_mul_rd = rd;
    else
      prev_mul_rd = '0;
    refresh_head();
  endtask

  task automatic idle();
    cycle_step();
    dispatch_v  = 1'b0;
    flush       = 1'b0;
    prev_mul_rd = '0;
  endtask

  task automatic drain();
    idle();
    while (exp_q.size() != 0)
    begin
      idle();
    end
    idle();
  endtask

  task automatic report(input string name);
    $display("%s done with %0d errors", name, errors - errors_mark);
    errors_mark = errors;
    tests_done  = tests_done + 1;
  endtask

  initial
  begin
    void'($urandom(32'h85df));
    clk = 1'b0;
    rst_n = 1'b0;
    dispatch_v = 1'b0;
    dispatch_op = calc_isa_pkg::op_add;
    dispatch_rd_addr = '0;
    dispatch_rs1_addr = '0;
    dispatch_rs2_addr = '0;
    dispatch_rs1_data = '0;
    dispatch_rs2_data = '0;
    flush = 1'b0;
    prev_mul_rd = '0;
    wb_pending = 1'b0;
    step_count = 0;
    cycle_count = 0;
    errors = 0;
    errors_mark = 0;
    tests_done = 0;
    wb_count = 0;
    // x0 holds garbage in the register file so only the DUT can zero it
    model_rf[0] = '0;
    stale_rf[0] = 32'hbad0_0001;
    for (int i = 1; i < 32; i++)
    begin
      model_rf[calc_geom_pkg::reg_addr_t'(i)] = $urandom;
      stale_rf[calc_geom_pkg::reg_addr_t'(i)] = model_rf[calc_geom_pkg::reg_addr_t'(i)];
    end
    refresh_head();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < n_alu; i++)
    begin
      send(calc_isa_pkg::calc_op_e'($urandom_range(5, 0)),
        calc_geom_pkg::reg_addr_t'($urandom_range(31, 16)), pick_src(0, 15), pick_src(0, 15), 1'b0);
    end
    drain();
    report("alu_random");

    for (int i = 0; i < n_mul; i++)
    begin
      send($urandom_range(1, 0) ? calc_isa_pkg::op_mulh : calc_isa_pkg::op_mul,
        calc_geom_pkg::reg_addr_t'($urandom_range(31, 1)), pick_src(1, 31), pick_src(1, 31), 1'b0);
    end
    drain();
    report("mul_signed");

    // Consumers at growing distances from an ALU and a multiply producer
    for (int d = 1; d <= 4; d++)
    begin
      send(calc_isa_pkg::op_add, 5'd5, 5'd1, 5'd2, 1'b0);
      repeat (d - 1) send(calc_isa_pkg::op_xor, 5'd20, 5'd11, 5'd12, 1'b0);
      send(calc_isa_pkg::op_sub, 5'd6, 5'd5, 5'd3, 1'b0);
      send(calc_isa_pkg::op_add, 5'd8, 5'd2, 5'd5, 1'b0);
    end
    for (int d = 2; d <= 4; d++)
    begin
      send(calc_isa_pkg::op_mul, 5'd7, 5'd1, 5'd8, 1'b0);
      repeat (d - 1) send(calc_isa_pkg::op_xor, 5'd20, 5'd11, 5'd12, 1'b0);
      send(calc_isa_pkg::op_mulh, 5'd9, 5'd7, 5'd3, 1'b0);
    end
    drain();
    report("dependent_chains");

    send(calc_isa_pkg::op_add, 5'd0, 5'd1, 5'd2, 1'b0);
    send(calc_isa_pkg::op_add, 5'd9, 5'd0, 5'd1, 1'b0);
    send(calc_isa_pkg::op_mul, 5'd0, 5'd3, 5'd4, 1'b0);
    send(calc_isa_pkg::op_or, 5'd10, 5'd0, 5'd0, 1'b0);
    send(calc_isa_pkg::op_sub, 5'd0, 5'd9, 5'd10, 1'b0);
    send(calc_isa_pkg::op_xor, 5'd11, 5'd0, 5'd9, 1'b0);
    drain();
    report("x0_handling");

    // Fill wb, ex3, ex2 and ex1, then flush alongside a new dispatch
    repeat (3)
    begin
      send(calc_isa_pkg::op_add, 5'd14, 5'd1, 5'd2, 1'b0);
      send(calc_isa_pkg::op_mul, 5'd15, 5'd14, 5'd3, 1'b0);
      send(calc_isa_pkg::op_sub, 5'd16, 5'd14, 5'd4, 1'b0);
      send(calc_isa_pkg::op_xor, 5'd17, 5'd15, 5'd16, 1'b0);
      send(calc_isa_pkg::op_add, 5'd18, 5'd16, 5'd17, 1'b1);
      send(calc_isa_pkg::op_or, 5'd19, 5'd15, 5'd16, 1'b0);
      // x1 is read two dispatches later by the next round
      send(calc_isa_pkg::op_mulh, 5'd1, 5'd15, 5'd17, 1'b0);
      send(calc_isa_pkg::op_add, 5'd21, 5'd17, 5'd14, 1'b0);
    end
    drain();
    report("flush");

    $display("%0d tests, %0d writebacks, %0d errors", tests_done, wb_count, errors);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
